// File: filelist.f
source/execPkg.sv
source/execDispatch.sv
source/scalarAlu.sv
source/ldStUnit.sv
source/moveBuffer.sv
source/execUnit.sv
bench/execUnit_checker.sv
bench/execUnitTb.sv

// File: Makefile
# Verilator build for the execution unit testbench

VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/execUnitTb.sv
// Testbench for the scalar execution unit with memory model and reference results
`timescale 1ns/1ns

module execUnitTb
	import execPkg::*;
();

	localparam int CmdCount = 60;                    // Upper bound on issued commands

	logic       clock;
	logic       rstN;
	logic       req;
	commandT    cmd;
	issueNoT    issueNo;
	dataT       src1, src2, src3;
	logic       stall;
	logic       busy;
	logic       wbValid;
	issueNoT    wbIssueNo;
	regIdxT     wbReg;
	dataT       wbData;
	logic       mathDone;
	logic [1:0] lsDone;
	logic       ldStall;
	logic [1:0] memReq, memWrite, memGrant, memEnd;
	addrT       memAddr [1:0];
	dataT       memStData [1:0];
	dataT       memLdData [1:0];

	int      seed = 32'h265b8f99;
	int      errors = 0;
	int      checks = 0;
	issueNoT nextNo;
	dataT    expData [256];
	regIdxT  expReg [256];
	logic    expPending [256];
	int      pendingCount = 0;
	issueNoT wbOrder [$];
	int      mathCount = 0;
	int      lsCount [2] = '{0, 0};
	int      reqRises = 0;
	logic [1:0] memReqPrev = '0;
	logic    stallWin = 1'b0;
	int      stallWb = 0;

	execUnit execUnit_i (.clock, .rstN, .req, .cmd, .issueNo, .src1, .src2, .src3, .stall,
		.busy, .wbValid, .wbIssueNo, .wbReg, .wbData, .mathDone, .lsDone, .ldStall,
		.memReq, .memWrite, .memAddr, .memStData, .memGrant, .memEnd, .memLdData);

	always #20 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Memory model, one per lane
	for (genvar l = 0; l < 2; l++) begin : memLane
		dataT words [256];
		logic grant;
		logic endP;
		dataT ldData;
		assign memGrant[l]  = grant;
		assign memEnd[l]    = endP;
		assign memLdData[l] = ldData;
		initial begin : serve
			int   gap;
			addrT a;
			logic wr;
			dataT st;
			for (int i = 0; i < 256; i++) begin
				words[i] = 32'hC300_0000 ^ (i * 32'h0001_0101) ^ (l * 32'h0080_0000);
			end
			grant  = 1'b0;
			endP   = 1'b0;
			ldData = '0;
			forever begin
				@(posedge clock);
				if (memReq[l]) begin
					a   = memAddr[l];
					wr  = memWrite[l];
					st  = memStData[l];
					gap = {$random(seed)} % 4;        // Grant after 0 to 3 cycles
					repeat (gap) @(posedge clock);
					#2 grant = 1'b1;
					@(posedge clock);
					#2 grant = 1'b0;
					gap = 1 + {$random(seed)} % 4;    // End 1 to 4 cycles later
					repeat (gap - 1) begin
						@(posedge clock);
						#2;
					end
					endP   = 1'b1;
					ldData = words[a[7:0]];
					if (wr) words[a[7:0]] = st;
					@(posedge clock);
					#2 endP = 1'b0;
				end
			end
		end
	end

	function automatic dataT peekWord(input int lane, input logic [7:0] a);
		return (lane == 1) ? memLane[1].words[a] : memLane[0].words[a];
	endfunction

	function automatic commandT makeCmd(input logic [1:0] t, input logic [1:0] c,
		input logic [3:0] code, input regIdxT dst);
		return {t, c, code, dst, 3'b000};
	endfunction

	// Expected result from the command rules
	function automatic dataT refResult(input commandT c, input dataT s1, input dataT s2,
		input dataT s3, input dataT memWord);
		if (c[15:14] == 2'b11) return memWord;
		if (c[13:12] == 2'b11 && c[11:8] != 4'd0) return s1;
		case (c[11:8])
			4'd0: return s1 + s2;
			4'd1: return s1 - s2;
			4'd2: return s1 & s2;
			4'd3: return s1 | s2;
			4'd4: return s1 ^ s2;
			4'd5: return s1 << s2[4:0];
			4'd6: return s1 >> s2[4:0];
			4'd7: return s1 * s2 + s3;
			default: return '0;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare process
	always @(posedge clock) begin
		if (rstN && wbValid) begin
			checks++;
			wbOrder.push_back(wbIssueNo);
			assert (expPending[wbIssueNo]) else begin
				$display("Write-back for issue %0d that was not pending", wbIssueNo);
				errors++;
			end
			if (expPending[wbIssueNo]) begin
				assert (wbData == expData[wbIssueNo]) else begin
					$display("[FAIL] wbData issue %h: got %h expected %h", wbIssueNo, wbData,
						expData[wbIssueNo]);
					errors++;
				end
				assert (wbReg == expReg[wbIssueNo]) else begin
					$display("[FAIL] wbReg issue %h: got %h expected %h", wbIssueNo, wbReg,
						expReg[wbIssueNo]);
					errors++;
				end
				expPending[wbIssueNo] = 1'b0;
				pendingCount--;
			end
		end
		if (mathDone) mathCount++;
		if (lsDone[0]) lsCount[0]++;
		if (lsDone[1]) lsCount[1]++;
		if (|(memReq & ~memReqPrev) && stallWin) reqRises++;
		memReqPrev = memReq;
		if (stallWin && wbValid) stallWb++;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	task automatic issue(input commandT c, input dataT s1, input dataT s2, input dataT s3);
		int lane;
		while (busy) begin
			@(posedge clock);
			#2;
		end
		lane = c[12];
		if (!(c[15:14] == 2'b11 && c[13])) begin          // Stores write nothing back
			expData[nextNo]    = refResult(c, s1, s2, s3, peekWord(lane, 8'(s1 + s2)));
			expReg[nextNo]     = c[7:3];
			expPending[nextNo] = 1'b1;
			pendingCount++;
		end
		req  = 1'b1;
		cmd  = c;
		src1 = s1;
		src2 = s2;
		src3 = s3;
		@(posedge clock);
		#2;
		req     = 1'b0;
		nextNo  = nextNo + 1'b1;
		issueNo = nextNo;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((pendingCount != 0 || busy) && n < 300) begin
			@(posedge clock);
			#2;
			n++;
		end
		assert (n < 300) else begin
			$display("Results still pending after draining");
			errors++;
		end
	endtask

	task automatic report(input string name, input int errBefore);
		$display("Test %s finished with %0d errors", name, errors - errBefore);
	endtask

	task automatic checkEq(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic dataT rnd();
		return $random(seed);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int      e0;
		int      m0;
		int      l0 [2];
		issueNoT first;
		clock = 1'b0;
		rstN  = 1'b0;
		req   = 1'b0;
		cmd   = '0;
		src1  = '0;
		src2  = '0;
		src3  = '0;
		stall = 1'b0;
		nextNo  = '0;
		issueNo = '0;
		for (int i = 0; i < 256; i++) expPending[i] = 1'b0;
		repeat (10) @(posedge clock);
		#2 rstN = 1'b1;

		// Reset state
		e0 = errors;
		checkEq("wbValid", wbValid, 0);
		checkEq("memReq", memReq, 0);
		checkEq("busy", busy, 0);
		checkEq("ldStall", ldStall, 0);
		report("reset", e0);

		// Arithmetic operations
		e0 = errors;
		m0 = mathCount;
		for (int op = 0; op < 8; op++) begin
			repeat (2) issue(makeCmd(2'b00, 2'b00, 4'(op), 5'(op + 1)), rnd(), rnd(), rnd());
		end
		drain();
		checkEq("mathDone count", mathCount - m0, 16);
		report("arith", e0);

		// Moves and a burst of eight
		e0 = errors;
		issue(makeCmd(2'b00, 2'b11, 4'd1, 5'd9), rnd(), rnd(), rnd());
		drain();
		wbOrder.delete();
		first = nextNo;
		for (int i = 0; i < 8; i++) issue(makeCmd(2'b00, 2'b11, 4'd1, 5'(i)), rnd(), 0, 0);
		drain();
		checkEq("move count", wbOrder.size(), 8);
		for (int i = 0; i < wbOrder.size(); i++) begin
			checkEq("move order wbIssueNo", wbOrder[i], 8'(first + i));
		end
		report("move", e0);

		// Loads and stores on both lanes
		e0 = errors;
		l0 = lsCount;
		for (int ln = 0; ln < 2; ln++) begin
			repeat (2) issue(makeCmd(2'b11, {1'b0, 1'(ln)}, 4'd0, 5'd20),
				rnd() & 32'h7f, rnd() & 32'h7f, 0);
			issue(makeCmd(2'b11, {1'b1, 1'(ln)}, 4'd0, 5'd0), 32'd40, 32'(ln * 9), rnd());
			issue(makeCmd(2'b11, {1'b0, 1'(ln)}, 4'd0, 5'd21), 32'd30, 32'(ln * 9 + 10), 0);
		end
		drain();
		checkEq("lsDone even", lsCount[0] - l0[0], 4);
		checkEq("lsDone odd", lsCount[1] - l0[1], 4);
		report("load/store", e0);

		// Mixed traffic with colliding results
		e0 = errors;
		for (int r = 0; r < 3; r++) begin
			wbOrder.delete();
			first = nextNo;
			issue(makeCmd(2'b00, 2'b00, 4'(r), 5'd3), rnd(), rnd(), rnd());
			issue(makeCmd(2'b00, 2'b11, 4'd2, 5'd4), rnd(), 0, 0);
			drain();
			checkEq("older first wbIssueNo", wbOrder[0], first);
			issue(makeCmd(2'b11, {1'b0, 1'(r)}, 4'd0, 5'd5), 32'(r * 7), 32'd3, 0);
			issue(makeCmd(2'b00, 2'b00, 4'd7, 5'd6), rnd(), rnd(), rnd());
			issue(makeCmd(2'b00, 2'b11, 4'd3, 5'd7), rnd(), 0, 0);
			drain();
		end
		report("mixed", e0);

		// Stall held for several cycles
		e0 = errors;
		issue(makeCmd(2'b00, 2'b00, 4'd7, 5'd12), rnd(), rnd(), rnd());
		stall    = 1'b1;
		stallWin = 1'b1;
		// Load accepted as the stall begins, its access must wait
		issue(makeCmd(2'b11, 2'b01, 4'd0, 5'd13), 32'd17, 32'd5, 0);
		repeat (5) @(posedge clock);
		#2;
		stallWin = 1'b0;
		stall    = 1'b0;
		checkEq("write-backs during stall", stallWb, 0);
		checkEq("memReq rises during stall", reqRises, 0);
		drain();
		report("stall", e0);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (CmdCount * 20 + 10) @(posedge clock);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/execUnit_checker.sv
// Write-back and take rules of the dispatch block as concurrent assertions
`timescale 1ns/1ns

module execUnit_checker (
	input logic       clock,
	input logic       rstN,
	input logic       wbValid,
	input logic       aluTake,
	input logic [1:0] laneTake,
	input logic       moveTake,
	input logic       aluReady,
	input logic [1:0] laneReady,
	input logic       moveReady
);

	logic [3:0] takes;
	assign takes = {laneTake, aluTake, moveTake};

	// One take per cycle, one write-back per take
	oneTake: assert property (@(posedge clock) disable iff (!rstN) $onehot0(takes))
		else $error("More than one take in a cycle");
	wbAfterTake: assert property (@(posedge clock) disable iff (!rstN) |takes |=> wbValid)
		else $error("Take without a write-back pulse");
	wbOnlyAfterTake: assert property (@(posedge clock) disable iff (!rstN)
		wbValid |-> $past(|takes)) else $error("Write-back without a take");

	takeNeedsReady: assert property (@(posedge clock) disable iff (!rstN)
		(!aluTake || aluReady) && (!moveTake || moveReady) && ((laneTake & ~laneReady) == 2'b00))
		else $error("Take without ready");

	quietAfterReset: assert property (@(posedge clock) $rose(rstN) |-> !wbValid)
		else $error("Write-back active right after reset");

endmodule

bind execDispatch execUnit_checker checkerI (.clock, .rstN, .wbValid, .aluTake, .laneTake,
	.moveTake, .aluReady, .laneReady, .moveReady);

// File: source/execUnit.sv
// Scalar execution unit top with dispatch, ALU, two load/store lanes and move buffer
`timescale 1ns/1ns

module execUnit
	import execPkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  logic       req,
	input  commandT    cmd,
	input  issueNoT    issueNo,
	input  dataT       src1,
	input  dataT       src2,
	input  dataT       src3,
	input  logic       stall,
	output logic       busy,
	output logic       wbValid,
	output issueNoT    wbIssueNo,
	output regIdxT     wbReg,
	output dataT       wbData,
	output logic       mathDone,
	output logic [1:0] lsDone,
	output logic       ldStall,
	output logic [1:0] memReq,                   // Bit 0 even lane, bit 1 odd lane
	output logic [1:0] memWrite,
	output addrT       memAddr [1:0],
	output dataT       memStData [1:0],
	input  logic [1:0] memGrant,
	input  logic [1:0] memEnd,
	input  dataT       memLdData [1:0]
);

	logic       aluReq, aluReady, aluTake, aluFull;
	issueNoT    aluIssueNo;
	regIdxT     aluReg;
	dataT       aluData;
	logic [1:0] laneReq, laneReady, laneTake, laneStall;
	issueNoT    laneIssueNo [1:0];
	regIdxT     laneReg [1:0];
	dataT       laneData [1:0];
	logic       moveReq, moveReady, moveTake, moveFull;
	issueNoT    moveIssueNo;
	regIdxT     moveReg;
	dataT       moveData;

	assign ldStall = |laneStall;
	assign busy    = aluFull || moveFull || ldStall;

	//////////////////////////////////////////////////////////////////////
	// Control and datapath blocks
	execDispatch dispatchI (.clock, .rstN, .req, .cmd, .issueNo,
		.aluReq, .laneReq, .moveReq, .aluReady, .aluIssueNo, .aluReg, .aluData,
		.laneReady, .laneIssueNo, .laneReg, .laneData,
		.moveReady, .moveIssueNo, .moveReg, .moveData,
		.aluTake, .laneTake, .moveTake, .wbValid, .wbIssueNo, .wbReg, .wbData);

	scalarAlu aluI (.clock, .rstN, .stall, .aluReq, .cmd, .issueNo, .src1, .src2, .src3,
		.aluTake, .aluReady, .aluIssueNo, .aluReg, .aluData, .aluFull, .mathDone);

	ldStUnit laneEvn (.clock, .rstN, .stall, .laneReq(laneReq[0]), .cmd, .issueNo,
		.src1, .src2, .src3, .laneTake(laneTake[0]),
		.memGrant(memGrant[0]), .memEnd(memEnd[0]), .memLdData(memLdData[0]),
		.memReq(memReq[0]), .memWrite(memWrite[0]), .memAddr(memAddr[0]),
		.memStData(memStData[0]), .laneReady(laneReady[0]), .laneIssueNo(laneIssueNo[0]),
		.laneReg(laneReg[0]), .laneData(laneData[0]), .lsDone(lsDone[0]),
		.ldStall(laneStall[0]));

	ldStUnit laneOdd (.clock, .rstN, .stall, .laneReq(laneReq[1]), .cmd, .issueNo,
		.src1, .src2, .src3, .laneTake(laneTake[1]),
		.memGrant(memGrant[1]), .memEnd(memEnd[1]), .memLdData(memLdData[1]),
		.memReq(memReq[1]), .memWrite(memWrite[1]), .memAddr(memAddr[1]),
		.memStData(memStData[1]), .laneReady(laneReady[1]), .laneIssueNo(laneIssueNo[1]),
		.laneReg(laneReg[1]), .laneData(laneData[1]), .lsDone(lsDone[1]),
		.ldStall(laneStall[1]));

	moveBuffer moveI (.clock, .rstN, .moveReq, .cmd, .issueNo, .src1, .moveTake,
		.moveReady, .moveIssueNo, .moveReg, .moveData, .moveFull);

endmodule

// File: source/moveBuffer.sv
// Ring buffer of pending register moves with their tokens and data
`timescale 1ns/1ns

module moveBuffer
	import execPkg::*;
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    moveReq,
	input  commandT cmd,
	input  issueNoT issueNo,
	input  dataT    src1,
	input  logic    moveTake,
	output logic    moveReady,
	output issueNoT moveIssueNo,
	output regIdxT  moveReg,
	output dataT    moveData,
	output logic    moveFull
);

	issueNoT                 issueMem [MoveDepth];
	regIdxT                  regMem [MoveDepth];
	dataT                    dataMem [MoveDepth];
	logic [MovePtrWidth-1:0] wrPtr;
	logic [MovePtrWidth-1:0] rdPtr;
	logic [MoveCntWidth-1:0] count;
	logic                    doWrite;
	logic                    doRead;

	function automatic logic [MovePtrWidth-1:0] nextPtr(input logic [MovePtrWidth-1:0] ptr);
		return (ptr == MovePtrWidth'(MoveDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign moveFull    = count == MoveCntWidth'(MoveDepth);
	assign moveReady   = count != '0;
	assign doWrite     = moveReq && !moveFull;
	assign doRead      = moveTake && moveReady;
	assign moveIssueNo = issueMem[rdPtr];        // Head entry
	assign moveReg     = regMem[rdPtr];
	assign moveData    = dataMem[rdPtr];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) wrPtr <= nextPtr(wrPtr);
			if (doRead) rdPtr <= nextPtr(rdPtr);
			count <= count + MoveCntWidth'(doWrite) - MoveCntWidth'(doRead);
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			issueMem[wrPtr] <= issueNo;
			regMem[wrPtr]   <= cmd[DstRegPos +: RegIdxWidth];
			dataMem[wrPtr]  <= src1;                   // Source passes through unchanged
		end
	end

endmodule

// File: source/ldStUnit.sv
// Load/store lane that runs one memory access and holds the loaded word
`timescale 1ns/1ns

module ldStUnit
	import execPkg::*;
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    stall,
	input  logic    laneReq,
	input  commandT cmd,
	input  issueNoT issueNo,
	input  dataT    src1,
	input  dataT    src2,
	input  dataT    src3,
	input  logic    laneTake,
	input  logic    memGrant,
	input  logic    memEnd,
	input  dataT    memLdData,
	output logic    memReq,
	output logic    memWrite,
	output addrT    memAddr,
	output dataT    memStData,
	output logic    laneReady,
	output issueNoT laneIssueNo,
	output regIdxT  laneReg,
	output dataT    laneData,
	output logic    lsDone,
	output logic    ldStall
);

	lsStateE state;
	logic    isStore;
	logic    accept;
	logic    accessEnd;

	assign accept    = laneReq && (state == LsIdle);
	assign accessEnd = memEnd && (state == LsWaitEnd);
	assign laneReady = state == LsHold;
	assign lsDone    = accessEnd;                // Loads and stores alike
	// Held from acceptance until the lane is idle again
	assign ldStall   = state != LsIdle;

	//////////////////////////////////////////////////////////////////////
	// Lane FSM
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state    <= LsIdle;
			memReq   <= 1'b0;
			memWrite <= 1'b0;
			isStore  <= 1'b0;
		end else begin
			case (state)
				LsIdle: begin
					if (laneReq) begin
						state    <= LsWaitGrant;
						memReq   <= !stall;
						memWrite <= cmd[OpClassPos + 1];       // Class bit 1 is store
						isStore  <= cmd[OpClassPos + 1];
					end
				end
				LsWaitGrant: begin
					if (memReq && memGrant) begin
						state    <= LsWaitEnd;
						memReq   <= 1'b0;                      // Drop after grant
						memWrite <= 1'b0;
					end else if (!stall) begin
						memReq   <= 1'b1;                      // Launch once stall clears
					end
				end
				LsWaitEnd: begin
					if (memEnd) begin
						state <= isStore ? LsIdle : LsHold;
					end
				end
				LsHold: begin
					if (laneTake) begin
						state <= LsIdle;
					end
				end
				default: state <= LsIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Access and result payload
	always_ff @(posedge clock) begin
		if (accept) begin
			memAddr     <= addrT'(src1 + src2);
			memStData   <= src3;
			laneIssueNo <= issueNo;
			laneReg     <= cmd[DstRegPos +: RegIdxWidth];
		end
		if (accessEnd && !isStore) begin
			laneData <= memLdData;
		end
	end

endmodule

// File: source/scalarAlu.sv
// Two-stage integer ALU pipeline with stall and a held output
`timescale 1ns/1ns

module scalarAlu
	import execPkg::*;
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    stall,
	input  logic    aluReq,
	input  commandT cmd,
	input  issueNoT issueNo,
	input  dataT    src1,
	input  dataT    src2,
	input  dataT    src3,
	input  logic    aluTake,
	output logic    aluReady,
	output issueNoT aluIssueNo,
	output regIdxT  aluReg,
	output dataT    aluData,
	output logic    aluFull,
	output logic    mathDone
);

	logic    valid1;
	logic    valid2;
	aluOpE   op1;
	dataT    opA;
	dataT    opB;
	dataT    opC;
	issueNoT issue1;
	regIdxT  reg1;
	dataT    result;
	logic    adv2;
	logic    load1;

	// Stage two moves on when empty or taken, stage one when it can pass along
	assign adv2     = !stall && (!valid2 || aluTake);
	assign load1    = !stall && (!valid1 || adv2);
	assign aluReady = valid2 && !stall;          // No write-back while stalled
	assign aluFull  = valid1 && valid2;
	assign mathDone = aluReady && aluTake;

	//////////////////////////////////////////////////////////////////////
	// Stage two datapath
	always_comb begin
		case (op1)
			OpAdd:   result = opA + opB;
			OpSub:   result = opA - opB;
			OpAnd:   result = opA & opB;
			OpOr:    result = opA | opB;
			OpXor:   result = opA ^ opB;
			OpSll:   result = opA << opB[ShiftWidth-1:0];
			OpSrl:   result = opA >> opB[ShiftWidth-1:0];
			OpMac:   result = opA * opB + opC;       // Truncated to 32 bits
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
		end else begin
			if (adv2) begin
				valid2 <= valid1;
			end
			if (load1) begin
				valid1 <= aluReq;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load1 && aluReq) begin
			op1    <= aluOpE'(cmd[OpCodePos +: OpCodeWidth]);
			opA    <= src1;
			opB    <= src2;
			opC    <= src3;
			issue1 <= issueNo;
			reg1   <= cmd[DstRegPos +: RegIdxWidth];
		end
		if (adv2 && valid1) begin
			aluData    <= result;
			aluIssueNo <= issue1;
			aluReg     <= reg1;
		end
	end

endmodule

// File: source/execDispatch.sv
// Dispatch control that decodes and steers commands and picks the oldest result
`timescale 1ns/1ns

module execDispatch
	import execPkg::*;
(
	input  logic       clock,
	input  logic       rstN,
	input  logic       req,
	input  commandT    cmd,
	input  issueNoT    issueNo,                // Also the age reference
	output logic       aluReq,
	output logic [1:0] laneReq,
	output logic       moveReq,
	input  logic       aluReady,
	input  issueNoT    aluIssueNo,
	input  regIdxT     aluReg,
	input  dataT       aluData,
	input  logic [1:0] laneReady,
	input  issueNoT    laneIssueNo [1:0],
	input  regIdxT     laneReg [1:0],
	input  dataT       laneData [1:0],
	input  logic       moveReady,
	input  issueNoT    moveIssueNo,
	input  regIdxT     moveReg,
	input  dataT       moveData,
	output logic       aluTake,
	output logic [1:0] laneTake,
	output logic       moveTake,
	output logic       wbValid,
	output issueNoT    wbIssueNo,
	output regIdxT     wbReg,
	output dataT       wbData
);

	logic [1:0]            opType;
	logic [1:0]            opClass;
	logic                  isMove;
	logic [WbSrcCount-1:0] srcReady;
	issueNoT               srcIssueNo [WbSrcCount];
	regIdxT                srcReg [WbSrcCount];
	dataT                  srcData [WbSrcCount];
	issueNoT               srcAge [WbSrcCount];
	issueNoT               bestAge;
	logic                  grantValid;
	logic [1:0]            grantIdx;
	logic [WbSrcCount-1:0] take;

	//////////////////////////////////////////////////////////////////////
	// Decode and steering
	assign opType     = cmd[OpTypePos +: 2];
	assign opClass    = cmd[OpClassPos +: 2];
	assign isMove     = (opType == OpTypeArith) && (opClass == OpClassMove) &&
		(|cmd[OpCodePos +: OpCodeWidth]);
	assign aluReq     = req && (opType == OpTypeArith) && !isMove;
	assign moveReq    = req && isMove;
	assign laneReq[0] = req && (opType == OpTypeLdSt) && !opClass[0];  // Even lane
	assign laneReq[1] = req && (opType == OpTypeLdSt) && opClass[0];   // Odd lane

	//////////////////////////////////////////////////////////////////////
	// Write-back arbitration by age
	assign srcReady = {laneReady[1], laneReady[0], aluReady, moveReady};
	assign srcIssueNo[SrcMove] = moveIssueNo;
	assign srcIssueNo[SrcAlu]  = aluIssueNo;
	assign srcIssueNo[SrcEvn]  = laneIssueNo[0];
	assign srcIssueNo[SrcOdd]  = laneIssueNo[1];
	assign srcReg[SrcMove]     = moveReg;
	assign srcReg[SrcAlu]      = aluReg;
	assign srcReg[SrcEvn]      = laneReg[0];
	assign srcReg[SrcOdd]      = laneReg[1];
	assign srcData[SrcMove]    = moveData;
	assign srcData[SrcAlu]     = aluData;
	assign srcData[SrcEvn]     = laneData[0];
	assign srcData[SrcOdd]     = laneData[1];

	always_comb begin
		grantValid = 1'b0;
		grantIdx   = SrcMove;
		bestAge    = '0;
		for (int i = 0; i < WbSrcCount; i++) begin
			srcAge[i] = issueNo - srcIssueNo[i];            // Modulo 256
			// Strictly older only, so earlier slots keep ties
			if (srcReady[i] && (!grantValid || (srcAge[i] > bestAge))) begin
				grantValid = 1'b1;
				grantIdx   = 2'(i);
				bestAge    = srcAge[i];
			end
		end
	end

	assign take     = grantValid ? (WbSrcCount'(1) << grantIdx) : '0;
	assign moveTake = take[SrcMove];
	assign aluTake  = take[SrcAlu];
	assign laneTake = {take[SrcOdd], take[SrcEvn]};

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= grantValid;                             // One pulse per take
		end
	end

	always_ff @(posedge clock) begin
		if (grantValid) begin
			wbIssueNo <= srcIssueNo[grantIdx];
			wbReg     <= srcReg[grantIdx];
			wbData    <= srcData[grantIdx];
		end
	end

endmodule

// File: source/execPkg.sv
// Execution unit package with widths, command layout, operation codes and states
package execPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and sizes
	localparam int DataWidth    = 32;
	localparam int IssueNoWidth = 8;
	localparam int RegIdxWidth  = 5;
	localparam int CmdWidth     = 16;
	localparam int AddrWidth    = 16;
	localparam int ShiftWidth   = 5;                     // Shift amount taken from src2
	localparam int MoveDepth    = 8;                     // Move buffer entries
	localparam int MovePtrWidth = $clog2(MoveDepth);
	localparam int MoveCntWidth = $clog2(MoveDepth + 1);
	localparam int WbSrcCount   = 4;                     // Write-back sources

	typedef logic [DataWidth-1:0]    dataT;
	typedef logic [IssueNoWidth-1:0] issueNoT;          // Wraps at 256
	typedef logic [RegIdxWidth-1:0]  regIdxT;
	typedef logic [CmdWidth-1:0]     commandT;
	typedef logic [AddrWidth-1:0]    addrT;

	//////////////////////////////////////////////////////////////////////
	// Command word layout, bits 2:0 are spare
	localparam int OpTypePos   = 14;                     // 2 bits
	localparam int OpClassPos  = 12;                     // 2 bits
	localparam int OpCodePos   = 8;
	localparam int OpCodeWidth = 4;
	localparam int DstRegPos   = 3;

	localparam logic [1:0] OpTypeArith = 2'b00;
	localparam logic [1:0] OpTypeLdSt  = 2'b11;
	localparam logic [1:0] OpClassMove = 2'b11;         // With nonzero code

	// Write-back source slots, lowest wins a tie
	localparam logic [1:0] SrcMove = 2'd0;
	localparam logic [1:0] SrcAlu  = 2'd1;
	localparam logic [1:0] SrcEvn  = 2'd2;
	localparam logic [1:0] SrcOdd  = 2'd3;

	typedef enum logic [OpCodeWidth-1:0] {
		OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSll, OpSrl, OpMac
	} aluOpE;

	typedef enum logic [1:0] {
		LsIdle, LsWaitGrant, LsWaitEnd, LsHold
	} lsStateE;

endpackage
